/* Bender.yml */
package:
  name: periph

sources:
  # design, package first
  - files:
      - logic/periph_pkg.sv
      - logic/periph_apb_ctrl.sv
      - logic/periph_ram.sv
      - logic/periph_gpio.sv
      - logic/periph_uart_tx.sv
      - logic/periph_top.sv

  # testbench
  - target: test
    files:
      - verification/periph_tb.sv

/* compile.f */
logic/periph_pkg.sv
logic/periph_apb_ctrl.sv
logic/periph_ram.sv
logic/periph_gpio.sv
logic/periph_uart_tx.sv
logic/periph_top.sv
verification/periph_tb.sv

/* logic/periph_apb_ctrl.sv */
/*
 * APB completer for the peripheral subsystem.
 * Decodes the address map, stalls UART writes while the transmitter
 * is busy, flags bad accesses and muxes read data.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_apb_ctrl #(
  parameter int unsigned NUM_GPIOS = 16
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // APB completer
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  periph_pkg::apb_addr_t  paddr_i,
  input  periph_pkg::apb_data_t  pwdata_i,
  output periph_pkg::apb_data_t  prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // scratch RAM
  output logic                   ram_req_o,
  output logic                   ram_we_o,
  output periph_pkg::ram_idx_t   ram_idx_o,
  output periph_pkg::apb_data_t  ram_wdata_o,
  input  periph_pkg::apb_data_t  ram_rdata_i,
  // GPIO bank
  output logic                   gpio_out_we_o,
  output logic                   gpio_oe_we_o,
  output logic [NUM_GPIOS-1:0]   gpio_wdata_o,
  input  logic [NUM_GPIOS-1:0]   gpio_out_q_i,
  input  logic [NUM_GPIOS-1:0]   gpio_oe_q_i,
  input  logic [NUM_GPIOS-1:0]   gpio_in_sync_i,
  // UART transmitter
  output logic                   tx_start_o,
  output periph_pkg::uart_byte_t tx_data_o,
  input  logic                   tx_busy_i
);

  import periph_pkg::*;

  logic ram_hit, out_hit, oe_hit, in_hit, data_hit, stat_hit;
  logic unmapped, acc_err;
  logic setup, access, stall, wr_ok;

  // region decode
  assign ram_hit  = (paddr_i >= RAM_BASE) && (paddr_i <= RAM_LAST);
  assign out_hit  = (paddr_i == GPIO_OUT_ADDR);
  assign oe_hit   = (paddr_i == GPIO_OE_ADDR);
  assign in_hit   = (paddr_i == GPIO_IN_ADDR);
  assign data_hit = (paddr_i == UART_DATA_ADDR);
  assign stat_hit = (paddr_i == UART_STATUS_ADDR);

  assign unmapped = !(ram_hit || out_hit || oe_hit || in_hit || data_hit || stat_hit);
  // read-only registers and the write-only data port
  assign acc_err  = unmapped || (pwrite_i && (in_hit || stat_hit)) || (!pwrite_i && data_hit);

  assign setup  = psel_i && !penable_i;
  assign access = psel_i && penable_i;
  // only back-pressure in the map
  assign stall  = data_hit && pwrite_i && tx_busy_i;
  assign wr_ok  = access && pwrite_i && !acc_err && !stall;

  assign pready_o  = access && !stall;
  assign pslverr_o = access && acc_err;

  // RAM read is issued in setup so data lands in the access phase
  assign ram_req_o   = setup && ram_hit;
  assign ram_we_o    = pwrite_i;
  assign ram_idx_o   = ram_idx_t'(paddr_i >> 2);
  assign ram_wdata_o = pwdata_i;

  assign gpio_out_we_o = wr_ok && out_hit;
  assign gpio_oe_we_o  = wr_ok && oe_hit;
  assign gpio_wdata_o  = pwdata_i[NUM_GPIOS-1:0];

  assign tx_start_o = wr_ok && data_hit;
  assign tx_data_o  = pwdata_i[UART_DW-1:0];

  // read mux, GPIO values zero-extended
  always_comb begin
    prdata_o = '0;
    if (ram_hit) begin
      prdata_o = ram_rdata_i;
    end else if (out_hit) begin
      prdata_o = apb_data_t'(gpio_out_q_i);
    end else if (oe_hit) begin
      prdata_o = apb_data_t'(gpio_oe_q_i);
    end else if (in_hit) begin
      prdata_o = apb_data_t'(gpio_in_sync_i);
    end else if (stat_hit) begin
      prdata_o = apb_data_t'(tx_busy_i);
    end
  end

  // completion only ever follows a setup or a stalled access
  a_pready_access : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pready_o |-> $past(psel_i && (!penable_i || !pready_o))
  );

  // a start must find the transmitter idle and make it busy
  a_start_idle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tx_start_o |-> !tx_busy_i ##1 tx_busy_i
  );

endmodule

`default_nettype wire

/* logic/periph_gpio.sv */
/*
 * GPIO bank with output and output-enable registers.
 * Pin inputs pass through a two-flop synchronizer.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_gpio #(
  parameter int unsigned NUM_GPIOS = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 out_we_i,
  input  logic                 oe_we_i,
  input  logic [NUM_GPIOS-1:0] wdata_i,
  input  logic [NUM_GPIOS-1:0] gpio_i,
  output logic [NUM_GPIOS-1:0] gpio_o,
  output logic [NUM_GPIOS-1:0] gpio_oe_o,
  output logic [NUM_GPIOS-1:0] in_sync_o
);

  logic [NUM_GPIOS-1:0] in_meta;

  // output and enable registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
    end else begin
      if (out_we_i) begin
        gpio_o <= wdata_i;
      end
      if (oe_we_i) begin
        gpio_oe_o <= wdata_i;
      end
    end
  end

  // first stage may go metastable, second one settles it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_meta   <= '0;
      in_sync_o <= '0;
    end else begin
      in_meta   <= gpio_i;
      in_sync_o <= in_meta;
    end
  end

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
/*
 * Peripheral subsystem package.
 * Bus and data widths, the APB register map and the shared width types.
 */

`default_nettype none

package periph_pkg;

  // bus widths
  localparam int unsigned APB_AW = 12;
  localparam int unsigned APB_DW = 32;
  localparam int unsigned UART_DW = 8;
  localparam int unsigned RAM_IDX_W = 6;

  typedef logic [APB_AW-1:0]    apb_addr_t;
  typedef logic [APB_DW-1:0]    apb_data_t;
  typedef logic [UART_DW-1:0]   uart_byte_t;
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;

  // scratch RAM window, one word per index
  localparam apb_addr_t RAM_BASE = 12'h000;
  localparam apb_addr_t RAM_LAST = 12'h0FC;

  // GPIO bank
  localparam apb_addr_t GPIO_OUT_ADDR = 12'h100;
  localparam apb_addr_t GPIO_OE_ADDR  = 12'h104;
  localparam apb_addr_t GPIO_IN_ADDR  = 12'h108;

  // UART transmitter, status bit 0 is busy
  localparam apb_addr_t UART_DATA_ADDR   = 12'h200;
  localparam apb_addr_t UART_STATUS_ADDR = 12'h204;

endpackage

`default_nettype wire

/* logic/periph_ram.sv */
/*
 * Scratch word memory, 64 entries.
 * Writes on request, otherwise registers the read word for the next cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_ram (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  periph_pkg::ram_idx_t  idx_i,
  input  periph_pkg::apb_data_t wdata_i,
  output periph_pkg::apb_data_t rdata_o
);

  import periph_pkg::*;

  localparam int unsigned DEPTH = 2 ** RAM_IDX_W;

  apb_data_t mem [DEPTH];

  // single port, read and write are exclusive
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx_i] <= wdata_i;
      end else begin
        rdata_o <= mem[idx_i];
      end
    end
  end

  // an unknown index would corrupt or read an arbitrary word
  a_idx_known : assert property (
    @(posedge clk_i)
    req_i |-> !$isunknown(idx_i) && !$isunknown(we_i)
  );

endmodule

`default_nettype wire

/* logic/periph_top.sv */
/*
 * Peripheral subsystem top.
 * APB decoder in front of scratch RAM, GPIO bank and UART transmitter.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_top #(
  parameter int unsigned NUM_GPIOS    = 16,
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // APB completer
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // pins
  input  logic [NUM_GPIOS-1:0]  gpio_i,
  output logic [NUM_GPIOS-1:0]  gpio_o,
  output logic [NUM_GPIOS-1:0]  gpio_oe_o,
  output logic                  txd_o
);

  import periph_pkg::*;

  logic                 ram_req, ram_we;
  ram_idx_t             ram_idx;
  apb_data_t            ram_wdata, ram_rdata;
  logic                 gpio_out_we, gpio_oe_we;
  logic [NUM_GPIOS-1:0] gpio_wdata, gpio_in_sync;
  logic                 tx_start, tx_busy;
  uart_byte_t           tx_data;

  periph_apb_ctrl #(
    .NUM_GPIOS (NUM_GPIOS)
  ) u_ctrl (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .ram_req_o      (ram_req),
    .ram_we_o       (ram_we),
    .ram_idx_o      (ram_idx),
    .ram_wdata_o    (ram_wdata),
    .ram_rdata_i    (ram_rdata),
    .gpio_out_we_o  (gpio_out_we),
    .gpio_oe_we_o   (gpio_oe_we),
    .gpio_wdata_o   (gpio_wdata),
    .gpio_out_q_i   (gpio_o),
    .gpio_oe_q_i    (gpio_oe_o),
    .gpio_in_sync_i (gpio_in_sync),
    .tx_start_o     (tx_start),
    .tx_data_o      (tx_data),
    .tx_busy_i      (tx_busy)
  );

  periph_ram u_ram (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  periph_gpio #(
    .NUM_GPIOS (NUM_GPIOS)
  ) u_gpio (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .out_we_i  (gpio_out_we),
    .oe_we_i   (gpio_oe_we),
    .wdata_i   (gpio_wdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .in_sync_o (gpio_in_sync)
  );

  periph_uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_data),
    .busy_o     (tx_busy),
    .txd_o      (txd_o)
  );

endmodule

`default_nettype wire

/* logic/periph_uart_tx.sv */
/*
 * Transmit-only UART, 8N1, line idles high.
 * A baud counter times each bit, a bit counter walks the shift register.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   tx_start_i,
  input  periph_pkg::uart_byte_t tx_data_i,
  output logic                   busy_o,
  output logic                   txd_o
);

  import periph_pkg::*;

  localparam int unsigned CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

  tx_state_e  state_q;
  logic [CW-1:0] baud_cnt;
  logic [2:0]    bit_cnt;
  uart_byte_t    shift_q;
  logic          bit_end;

  assign bit_end = (baud_cnt == CW'(CLKS_PER_BIT - 1));
  assign busy_o  = (state_q != IDLE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd_o    <= 1'b1;
    end else begin
      baud_cnt <= (state_q == IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
      unique case (state_q)
        IDLE: begin
          if (tx_start_i) begin
            state_q <= START;
            txd_o   <= 1'b0;
          end
        end
        START: begin
          if (bit_end) begin
            state_q <= DATA;
            bit_cnt <= '0;
            txd_o   <= shift_q[0];
          end
        end
        DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            // lsb first, stop bit after the eighth
            if (bit_cnt == 3'd7) begin
              state_q <= STOP;
              txd_o   <= 1'b1;
            end else begin
              txd_o <= shift_q[1];
            end
          end
        end
        STOP: begin
          if (bit_end) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // payload shift register
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && tx_start_i) begin
      shift_q <= tx_data_i;
    end else if (state_q == DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  a_idle_high : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q == IDLE) |-> txd_o
  );

  // the APB side must hold off while a frame is on the line
  a_no_start_busy : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tx_start_i |-> (state_q == IDLE)
  );

endmodule

`default_nettype wire

/* verification/periph_tb.sv */
/*
 * Peripheral subsystem testbench.
 * Drives APB transfers, watches the GPIO pins and decodes UART frames
 * against a reference model of the register map.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_tb;

  import periph_pkg::*;

  localparam int unsigned NUM_GPIOS    = 16;
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int N_XFERS     = 240;
  localparam int N_BYTES     = 4;
  localparam int CYCLE_LIMIT = N_XFERS * 4 + N_BYTES * 10 * CLKS_PER_BIT * 2 + 100;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 psel_i, penable_i, pwrite_i;
  apb_addr_t            paddr_i;
  apb_data_t            pwdata_i, prdata_o;
  logic                 pready_o, pslverr_o;
  logic [NUM_GPIOS-1:0] gpio_i, gpio_o, gpio_oe_o;
  logic                 txd_o;

  // reference model state
  apb_data_t            model_ram [64];
  logic [63:0]          ram_written;
  logic [NUM_GPIOS-1:0] model_out, model_oe, model_in;
  logic                 model_busy;

  uart_byte_t rx_q [$];
  uart_byte_t exp_q [$];
  int         frames_seen;
  int         cycles;
  logic [15:0] lfsr_q;

  periph_top #(
    .NUM_GPIOS    (NUM_GPIOS),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) UUT (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .txd_o     (txd_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_gpio(input string name, input logic [NUM_GPIOS-1:0] exp,
                            input logic [NUM_GPIOS-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(input int nbits, output apb_data_t val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  // expected read data from the register map rules
  function automatic apb_data_t ref_read(input apb_addr_t addr);
    if (addr <= RAM_LAST) begin
      return model_ram[addr[7:2]];
    end
    case (addr)
      GPIO_OUT_ADDR:    return apb_data_t'(model_out);
      GPIO_OE_ADDR:     return apb_data_t'(model_oe);
      GPIO_IN_ADDR:     return apb_data_t'(model_in);
      UART_STATUS_ADDR: return apb_data_t'(model_busy);
      default:          return '0;
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // setup then access, completion sampled mid-cycle
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                           output logic err, output int waits);
    waits = 0;
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = 1'b1;
    paddr_i = addr;
    pwdata_i = data;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    while (!pready_o) begin
      waits++;
      @(negedge clk_i);
    end
    err = pslverr_o;
    @(posedge clk_i);
    #1;
    psel_i = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    int waits;
    waits = 0;
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = addr;
    pwdata_i = '0;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    while (!pready_o) begin
      waits++;
      @(negedge clk_i);
    end
    data = prdata_o;
    err = pslverr_o;
    @(posedge clk_i);
    #1;
    psel_i = 1'b0;
    penable_i = 1'b0;
    if (waits != 0) begin
      fail_run($sformatf("read of %h took %0d wait states instead of none", addr, waits));
    end
  endtask

  task automatic do_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    logic err;
    int   waits;
    apb_write(addr, data, err, waits);
    if (waits != 0) begin
      fail_run($sformatf("write to %h took %0d wait states instead of none", addr, waits));
    end
    check_err($sformatf("pslverr write %h", addr), exp_err, err);
  endtask

  task automatic expect_read(input apb_addr_t addr);
    apb_data_t data;
    logic      err;
    apb_read(addr, data, err);
    check_err($sformatf("pslverr read %h", addr), 1'b0, err);
    check_word($sformatf("prdata %h", addr), ref_read(addr), data);
  endtask

  // mid-bit sampling of each frame on txd_o
  initial begin : uart_monitor
    uart_byte_t b;
    wait (arst_n_i === 1'b1);
    forever begin
      @(negedge txd_o);
      repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
      if (txd_o !== 1'b0) begin
        fail_run("UART start bit did not stay low until mid-bit");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        b[i] = txd_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk_i);
      if (txd_o !== 1'b1) begin
        fail_run("UART stop bit was not high");
      end
      rx_q.push_back(b);
    end
  end

  initial begin : frame_compare
    uart_byte_t got;
    forever begin
      wait (rx_q.size() > 0);
      got = rx_q.pop_front();
      if (exp_q.size() == 0) begin
        fail_run("UART frame arrived with no byte written");
      end else begin
        check_byte("txd_o frame", exp_q.pop_front(), got);
        frames_seen++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout, test did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin : main
    apb_data_t d, r;
    ram_idx_t  idx;
    logic      err;
    int        waits;
    arst_n_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    gpio_i = '0;
    model_out = '0;
    model_oe = '0;
    model_in = '0;
    model_busy = 1'b0;
    ram_written = '0;
    frames_seen = 0;
    cycles = 0;
    lfsr_q = 16'd30236;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // reset state
    if (txd_o !== 1'b1) begin
      fail_run("txd_o was not idle high after reset");
    end
    check_gpio("gpio_o", '0, gpio_o);
    check_gpio("gpio_oe_o", '0, gpio_oe_o);
    expect_read(UART_STATUS_ADDR);

    // scratch RAM, random indices
    for (int k = 0; k < 64; k++) begin
      rand_word(RAM_IDX_W, r);
      idx = ram_idx_t'(r);
      rand_word(32, d);
      do_write(apb_addr_t'(idx) << 2, d, 1'b0);
      model_ram[idx] = d;
      ram_written[idx] = 1'b1;
    end
    for (int k = 0; k < 64; k++) begin
      if (ram_written[k]) expect_read(apb_addr_t'(k) << 2);
    end

    // GPIO outputs and enables
    for (int k = 0; k < 4; k++) begin
      rand_word(32, d);
      do_write(GPIO_OUT_ADDR, d, 1'b0);
      model_out = d[NUM_GPIOS-1:0];
      check_gpio("gpio_o", model_out, gpio_o);
      rand_word(32, d);
      do_write(GPIO_OE_ADDR, d, 1'b0);
      model_oe = d[NUM_GPIOS-1:0];
      check_gpio("gpio_oe_o", model_oe, gpio_oe_o);
      expect_read(GPIO_OUT_ADDR);
      expect_read(GPIO_OE_ADDR);
    end

    // GPIO inputs through the synchronizer
    for (int k = 0; k < 2; k++) begin
      rand_word(NUM_GPIOS, d);
      gpio_i = d[NUM_GPIOS-1:0];
      model_in = d[NUM_GPIOS-1:0];
      idle(3);
      expect_read(GPIO_IN_ADDR);
    end

    // back-to-back UART bytes, later ones stall
    for (int k = 0; k < N_BYTES; k++) begin
      rand_word(8, d);
      exp_q.push_back(d[7:0]);
      apb_write(UART_DATA_ADDR, d, err, waits);
      check_err("pslverr UART_DATA write", 1'b0, err);
      if (k == 1 && waits == 0) begin
        fail_run("second UART write completed without stalling on a busy transmitter");
      end
    end
    model_busy = 1'b1;
    expect_read(UART_STATUS_ADDR);
    wait (frames_seen == N_BYTES);
    idle(CLKS_PER_BIT);
    model_busy = 1'b0;
    expect_read(UART_STATUS_ADDR);

    // error responses, no side effects
    rand_word(32, d);
    do_write(12'h10C, d, 1'b1);
    do_write(12'h3F0, d, 1'b1);
    do_write(GPIO_IN_ADDR, d, 1'b1);
    do_write(UART_STATUS_ADDR, d, 1'b1);
    apb_read(UART_DATA_ADDR, r, err);
    check_err("pslverr UART_DATA read", 1'b1, err);
    expect_read(GPIO_OUT_ADDR);
    expect_read(GPIO_OE_ADDR);
    expect_read(GPIO_IN_ADDR);
    expect_read(UART_STATUS_ADDR);
    for (int k = 0; k < 64; k++) begin
      if (ram_written[k]) expect_read(apb_addr_t'(k) << 2);
    end
    check_gpio("gpio_o", model_out, gpio_o);
    check_gpio("gpio_oe_o", model_oe, gpio_oe_o);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
